// ==== common/fwrisc_core_pkg.sv ====
//==========================================================================
// Internal control types of the core: the sequencing state and the
// write-back source. Shared by control, decode and the protocol checker.
//==========================================================================

package fwrisc_core_pkg;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEM
	} state_e;

	typedef enum logic [1:0] {
		WB_ALU,      // ALU result
		WB_PC_PLUS4, // Link address
		WB_LOAD,     // Data port read
		WB_NONE      // No register write
	} wb_sel_e;

endpackage

// ==== common/fwrisc_isa_pkg.sv ====
//==========================================================================
// RV32I instruction set encodings used by decode, the ALU and the
// testbench reference model. Major opcodes, ALU operations and branch
// conditions as they appear in the instruction word.
//==========================================================================

package fwrisc_isa_pkg;

	// Major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// Encoded as {funct7[5], funct3} where the ISA allows it
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SUB  = 4'b1000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_SRA  = 4'b1101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111
	} alu_op_e;

	// Branch funct3 values
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_cond_e;

endpackage

// ==== common/fwrisc_params.svh ====
//==========================================================================
// Build-time settings for the core: reset vector, register count and
// data width. Included by every RTL file and by the testbench.
//==========================================================================

`ifndef FWRISC_PARAMS_SVH
`define FWRISC_PARAMS_SVH

// First pc after reset
`define FWRISC_RESET_VECTOR 32'h0000_0000

// Architectural integer registers, x0 included
`define FWRISC_NUM_REGS 32

// Data path and address width
`define FWRISC_XLEN 32

`endif

// ==== filelist.f ====
+incdir+common
common/fwrisc_isa_pkg.sv
common/fwrisc_core_pkg.sv
hw/fwrisc_alu.sv
hw/fwrisc_regfile.sv
hw/fwrisc_decode.sv
hw/fwrisc_control.sv
hw/fwrisc.sv
tests/fwrisc_tb_sva.sv
tests/fwrisc_tb.sv

// ==== hw/fwrisc.sv ====
//==========================================================================
// Top level of the multi-cycle RV32I core. Wires control, decode,
// register file and ALU together and exposes the instruction and data
// ports with their valid/ready handshakes.
//==========================================================================

`timescale 1ns/1ps

`include "fwrisc_params.svh"

module fwrisc (
	input  logic                   clock,
	input  logic                   reset,

	output logic [`FWRISC_XLEN-1:0] iaddr,
	input  logic [`FWRISC_XLEN-1:0] idata,
	output logic                   ivalid,
	input  logic                   iready,

	output logic [`FWRISC_XLEN-1:0] daddr,
	output logic [`FWRISC_XLEN-1:0] dwdata,
	input  logic [`FWRISC_XLEN-1:0] drdata,
	output logic [3:0]             dstrb,
	output logic                   dwrite,
	output logic                   dvalid,
	input  logic                   dready
);
	import fwrisc_isa_pkg::*;
	import fwrisc_core_pkg::*;

	logic [`FWRISC_XLEN-1:0] instr;
	logic [4:0]              rs1;
	logic [4:0]              rs2;
	logic [4:0]              rd;
	logic [`FWRISC_XLEN-1:0] imm;
	alu_op_e                 alu_op;
	logic                    alu_src_imm;
	logic                    alu_src_pc;
	branch_cond_e            branch_cond;
	logic                    is_branch;
	logic                    is_jal;
	logic                    is_jalr;
	logic                    is_load;
	logic                    is_store;
	wb_sel_e                 wb_sel;

	logic [`FWRISC_XLEN-1:0] rs1_data;
	logic [`FWRISC_XLEN-1:0] rs2_data;
	logic [4:0]              rd_waddr;
	logic [`FWRISC_XLEN-1:0] rd_wdata;
	logic                    rd_wen;

	logic [`FWRISC_XLEN-1:0] alu_a;
	logic [`FWRISC_XLEN-1:0] alu_b;
	logic [`FWRISC_XLEN-1:0] alu_out;

	fwrisc_control u_control (
		.clock       (clock),       .reset       (reset),
		.iaddr       (iaddr),       .idata       (idata),
		.ivalid      (ivalid),      .iready      (iready),
		.daddr       (daddr),       .dwdata      (dwdata),
		.drdata      (drdata),      .dstrb       (dstrb),
		.dwrite      (dwrite),      .dvalid      (dvalid),
		.dready      (dready),      .instr       (instr),
		.rd          (rd),          .imm         (imm),
		.alu_src_imm (alu_src_imm), .alu_src_pc  (alu_src_pc),
		.is_branch   (is_branch),   .branch_cond (branch_cond),
		.is_jal      (is_jal),      .is_jalr     (is_jalr),
		.is_load     (is_load),     .is_store    (is_store),
		.wb_sel      (wb_sel),      .rs1_data    (rs1_data),
		.rs2_data    (rs2_data),    .rd_waddr    (rd_waddr),
		.rd_wdata    (rd_wdata),    .rd_wen      (rd_wen),
		.alu_a       (alu_a),       .alu_b       (alu_b),
		.alu_out     (alu_out)
	);

	fwrisc_decode u_decode (
		.instr       (instr),       .rs1         (rs1),
		.rs2         (rs2),         .rd          (rd),
		.imm         (imm),         .alu_op      (alu_op),
		.alu_src_imm (alu_src_imm), .alu_src_pc  (alu_src_pc),
		.branch_cond (branch_cond), .is_branch   (is_branch),
		.is_jal      (is_jal),      .is_jalr     (is_jalr),
		.is_load     (is_load),     .is_store    (is_store),
		.wb_sel      (wb_sel)
	);

	fwrisc_regfile u_regfile (
		.clock    (clock),    .reset    (reset),
		.rs1_addr (rs1),      .rs2_addr (rs2),
		.rs1_data (rs1_data), .rs2_data (rs2_data),
		.rd_waddr (rd_waddr), .rd_wdata (rd_wdata),
		.rd_wen   (rd_wen)
	);

	fwrisc_alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.op     (alu_op),
		.result (alu_out)
	);

endmodule

// ==== hw/fwrisc_alu.sv ====
//==========================================================================
// Combinational RV32I ALU. Covers add, subtract, the logic operations,
// the three shifts and the signed and unsigned compares.
//==========================================================================

`timescale 1ns/1ps

`include "fwrisc_params.svh"

module fwrisc_alu (
	input  logic [`FWRISC_XLEN-1:0] a,
	input  logic [`FWRISC_XLEN-1:0] b,
	input  fwrisc_isa_pkg::alu_op_e op,
	output logic [`FWRISC_XLEN-1:0] result
);
	import fwrisc_isa_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b[4:0]; // Upper bits ignored per RV32I
	assign lt_signed   = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLL:  result = a << shamt;
			ALU_SLT:  result = {{(`FWRISC_XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(`FWRISC_XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:  result = a ^ b;
			ALU_SRL:  result = a >> shamt;
			ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
			ALU_OR:   result = a | b;
			ALU_AND:  result = a & b;
			default:  result = '0;
		endcase
	end

endmodule

// ==== hw/fwrisc_control.sv ====
//==========================================================================
// Sequencer of the core. Steps each instruction through fetch, decode,
// execute and an optional memory phase, owns the pc and register write
// back, and drives the instruction and data port handshakes.
//==========================================================================

`timescale 1ns/1ps

`include "fwrisc_params.svh"

module fwrisc_control (
	input  logic                         clock,
	input  logic                         reset,

	output logic [`FWRISC_XLEN-1:0]       iaddr,
	input  logic [`FWRISC_XLEN-1:0]       idata,
	output logic                         ivalid,
	input  logic                         iready,

	output logic [`FWRISC_XLEN-1:0]       daddr,
	output logic [`FWRISC_XLEN-1:0]       dwdata,
	input  logic [`FWRISC_XLEN-1:0]       drdata,
	output logic [3:0]                   dstrb,
	output logic                         dwrite,
	output logic                         dvalid,
	input  logic                         dready,

	output logic [`FWRISC_XLEN-1:0]       instr,
	input  logic [4:0]                   rd,
	input  logic [`FWRISC_XLEN-1:0]       imm,
	input  logic                         alu_src_imm,
	input  logic                         alu_src_pc,
	input  logic                         is_branch,
	input  fwrisc_isa_pkg::branch_cond_e branch_cond,
	input  logic                         is_jal,
	input  logic                         is_jalr,
	input  logic                         is_load,
	input  logic                         is_store,
	input  fwrisc_core_pkg::wb_sel_e     wb_sel,

	input  logic [`FWRISC_XLEN-1:0]       rs1_data,
	input  logic [`FWRISC_XLEN-1:0]       rs2_data,
	output logic [4:0]                   rd_waddr,
	output logic [`FWRISC_XLEN-1:0]       rd_wdata,
	output logic                         rd_wen,

	output logic [`FWRISC_XLEN-1:0]       alu_a,
	output logic [`FWRISC_XLEN-1:0]       alu_b,
	input  logic [`FWRISC_XLEN-1:0]       alu_out
);
	import fwrisc_isa_pkg::*;
	import fwrisc_core_pkg::*;

	state_e                  state;
	logic [`FWRISC_XLEN-1:0] pc;
	logic [`FWRISC_XLEN-1:0] pc_plus4;
	logic [`FWRISC_XLEN-1:0] pc_next;
	logic                    fetch_en; // Low for the cycle reset is released
	logic                    taken;
	logic                    mem_done;

	assign pc_plus4 = pc + 32'd4;

	assign iaddr  = pc;
	assign ivalid = (state == ST_FETCH) && fetch_en;

	// Word accesses only, address comes straight from the ALU sum
	assign dvalid   = (state == ST_MEM);
	assign dwrite   = dvalid && is_store;
	assign daddr    = alu_out;
	assign dwdata   = rs2_data;
	assign dstrb    = 4'hf;
	assign mem_done = dvalid && dready;

	assign alu_a = alu_src_pc ? pc : rs1_data;
	assign alu_b = alu_src_imm ? imm : rs2_data;

	always_comb begin
		case (branch_cond)
			BR_BEQ:  taken = (rs1_data == rs2_data);
			BR_BNE:  taken = (rs1_data != rs2_data);
			BR_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
			BR_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
			BR_BLTU: taken = (rs1_data < rs2_data);
			BR_BGEU: taken = (rs1_data >= rs2_data);
			default: taken = 1'b0;
		endcase
	end

	// Branch and JAL targets come from the ALU as pc + imm
	always_comb begin
		if (is_jalr) begin
			pc_next = {alu_out[`FWRISC_XLEN-1:1], 1'b0};
		end else if (is_jal || (is_branch && taken)) begin
			pc_next = alu_out;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_comb begin
		case (wb_sel)
			WB_PC_PLUS4: rd_wdata = pc_plus4;
			WB_LOAD:     rd_wdata = drdata;
			default:     rd_wdata = alu_out;
		endcase
	end

	assign rd_waddr = rd;

	// x0 is never written
	assign rd_wen = (rd != 5'd0) && (wb_sel != WB_NONE) &&
		(((state == ST_EXECUTE) && !is_load && !is_store) || (mem_done && is_load));

	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= ST_FETCH;
			pc       <= `FWRISC_RESET_VECTOR;
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			case (state)
				ST_FETCH: begin
					if (ivalid && iready) state <= ST_DECODE;
				end
				ST_DECODE: state <= ST_EXECUTE; // Decode settles in one cycle
				ST_EXECUTE: begin
					if (is_load || is_store) begin
						state <= ST_MEM;
					end else begin
						pc    <= pc_next;
						state <= ST_FETCH;
					end
				end
				default: begin
					if (mem_done) begin
						pc    <= pc_plus4;
						state <= ST_FETCH;
					end
				end
			endcase
		end
	end

endmodule

// ==== hw/fwrisc_decode.sv ====
//==========================================================================
// Combinational decoder for the latched instruction. Extracts register
// fields, classifies the major opcode, builds the immediate and picks
// the ALU operation and write-back source.
//==========================================================================

`timescale 1ns/1ps

`include "fwrisc_params.svh"

module fwrisc_decode (
	input  logic [`FWRISC_XLEN-1:0]       instr,
	output logic [4:0]                   rs1,
	output logic [4:0]                   rs2,
	output logic [4:0]                   rd,
	output logic [`FWRISC_XLEN-1:0]       imm,
	output fwrisc_isa_pkg::alu_op_e      alu_op,
	output logic                         alu_src_imm,
	output logic                         alu_src_pc,
	output fwrisc_isa_pkg::branch_cond_e branch_cond,
	output logic                         is_branch,
	output logic                         is_jal,
	output logic                         is_jalr,
	output logic                         is_load,
	output logic                         is_store,
	output fwrisc_core_pkg::wb_sel_e     wb_sel
);
	import fwrisc_isa_pkg::*;
	import fwrisc_core_pkg::*;

	opcode_e                 opcode;
	logic [2:0]              funct3;
	logic                    funct7_b5;
	alu_op_e                 arith_op;
	logic [`FWRISC_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode    = opcode_e'(instr[6:0]);
	assign funct3    = instr[14:12];
	assign funct7_b5 = instr[30];
	assign rs2       = instr[24:20];
	assign rd        = instr[11:7];

	assign branch_cond = branch_cond_e'(funct3);

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Bit 30 picks SUB only for register ops; immediates reuse it for SRAI
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		rs1         = instr[19:15];
		imm         = imm_i;
		alu_op      = ALU_ADD;
		alu_src_imm = 1'b0;
		alu_src_pc  = 1'b0;
		is_branch   = 1'b0;
		is_jal      = 1'b0;
		is_jalr     = 1'b0;
		is_load     = 1'b0;
		is_store    = 1'b0;
		wb_sel      = WB_NONE;
		case (opcode)
			OPC_LUI: begin
				rs1         = 5'd0; // x0 + imm
				imm         = imm_u;
				alu_src_imm = 1'b1;
				wb_sel      = WB_ALU;
			end
			OPC_AUIPC: begin
				imm         = imm_u;
				alu_src_imm = 1'b1;
				alu_src_pc  = 1'b1;
				wb_sel      = WB_ALU;
			end
			OPC_JAL: begin
				imm         = imm_j;
				alu_src_imm = 1'b1;
				alu_src_pc  = 1'b1;
				is_jal      = 1'b1;
				wb_sel      = WB_PC_PLUS4;
			end
			OPC_JALR: begin
				alu_src_imm = 1'b1;
				is_jalr     = 1'b1;
				wb_sel      = WB_PC_PLUS4;
			end
			OPC_BRANCH: begin
				imm         = imm_b;
				alu_src_imm = 1'b1;
				alu_src_pc  = 1'b1; // Target in the ALU, compare in control
				is_branch   = 1'b1;
			end
			OPC_LOAD: begin
				alu_src_imm = 1'b1;
				is_load     = 1'b1;
				wb_sel      = WB_LOAD;
			end
			OPC_STORE: begin
				imm         = imm_s;
				alu_src_imm = 1'b1;
				is_store    = 1'b1;
			end
			OPC_OP_IMM: begin
				alu_op      = arith_op;
				alu_src_imm = 1'b1;
				wb_sel      = WB_ALU;
			end
			OPC_OP: begin
				alu_op = arith_op;
				wb_sel = WB_ALU;
			end
			default: ; // Retires as a no-op
		endcase
	end

endmodule

// ==== hw/fwrisc_regfile.sv ====
//==========================================================================
// Integer register file with two combinational read ports and one
// synchronous write port. Register x0 always reads as zero.
//==========================================================================

`timescale 1ns/1ps

`include "fwrisc_params.svh"

module fwrisc_regfile (
	input  logic                   clock,
	input  logic                   reset,
	input  logic [4:0]             rs1_addr,
	input  logic [4:0]             rs2_addr,
	output logic [`FWRISC_XLEN-1:0] rs1_data,
	output logic [`FWRISC_XLEN-1:0] rs2_data,
	input  logic [4:0]             rd_waddr,
	input  logic [`FWRISC_XLEN-1:0] rd_wdata,
	input  logic                   rd_wen
);

	logic [`FWRISC_XLEN-1:0] regs [`FWRISC_NUM_REGS];

	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `FWRISC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen && rd_waddr != 5'd0) begin
			regs[rd_waddr] <= rd_wdata;
		end
	end

endmodule

// ==== tests/fwrisc_tb.sv ====
//==========================================================================
// Testbench for the RV32I core. Runs a preamble plus a random ALU program
// from stalling instruction and data memories, and checks every fetch
// address and store against an instruction-set model.
//==========================================================================

`timescale 1ns/1ps

`include "fwrisc_params.svh"

module fwrisc_tb;
	import fwrisc_isa_pkg::*;

	logic        clock = 1'b0;
	logic        reset;
	logic [31:0] iaddr;
	logic [31:0] idata;
	logic        ivalid;
	logic        iready;
	logic [31:0] daddr;
	logic [31:0] dwdata;
	logic [31:0] drdata;
	logic [3:0]  dstrb;
	logic        dwrite;
	logic        dvalid;
	logic        dready;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] ref_dmem [256];
	logic [31:0] ref_regs [`FWRISC_NUM_REGS];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] rng_state;
	logic [31:0] exp_pc;
	logic [31:0] halt_pc;
	logic [31:0] slot_addr;
	int          prog_len;
	int          halt_hits;
	int          cycles;
	int          cycle_limit;

	// Handshakes seen at the falling edge, checked at the next rising edge
	logic        fetch_fire;
	logic [31:0] fetch_addr;
	logic        store_fire;
	logic [31:0] store_addr;
	logic [31:0] store_data;
	logic [3:0]  store_strb;

	fwrisc dut_i (
		.clock  (clock),  .reset  (reset),
		.iaddr  (iaddr),  .idata  (idata),
		.ivalid (ivalid), .iready (iready),
		.daddr  (daddr),  .dwdata (dwdata),
		.drdata (drdata), .dstrb  (dstrb),
		.dwrite (dwrite), .dvalid (dvalid),
		.dready (dready)
	);

	always #2 clock = ~clock;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			report_failure($sformatf("ERR %0t %s: got %h, expected %h", $time, name, got, exp));
		end
	endtask

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			BR_BEQ:  return a == b;
			BR_BNE:  return a != b;
			BR_BLT:  return $signed(a) < $signed(b);
			BR_BGE:  return $signed(a) >= $signed(b);
			BR_BLTU: return a < b;
			BR_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'd0, $signed(a) < $signed(b)};
			3'b011:  return {31'd0, a < b};
			3'b100:  return a ^ b;
			3'b101: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end else begin
					return a >> b[4:0];
				end
			end
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	// Instruction-set model: one instruction, returns the next pc
	function automatic logic [31:0] ref_step(input logic [31:0] pc, input logic [31:0] ins);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] addr;
		logic [31:0] res;
		logic [31:0] nxt;
		logic        wr;
		a     = ref_regs[ins[19:15]];
		b     = ref_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		res   = '0;
		nxt   = pc + 32'd4;
		wr    = 1'b1;
		case (ins[6:0])
			OPC_LUI:   res = {ins[31:12], 12'h000};
			OPC_AUIPC: res = pc + {ins[31:12], 12'h000};
			OPC_JAL: begin
				res = pc + 32'd4;
				nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			OPC_JALR: begin
				res = pc + 32'd4;
				nxt = (a + imm_i) & ~32'd1;
			end
			OPC_BRANCH: begin
				wr = 1'b0;
				if (branch_taken(ins[14:12], a, b)) begin
					nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
				end
			end
			OPC_LOAD: begin
				addr = a + imm_i;
				res  = ref_dmem[addr[9:2]];
			end
			OPC_STORE: begin
				wr   = 1'b0;
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				ref_dmem[addr[9:2]] = b;
				exp_addr_q.push_back(addr);
				exp_data_q.push_back(b);
			end
			OPC_OP_IMM: res = alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
			OPC_OP:     res = alu_ref(ins[14:12], ins[30], a, b);
			default:    wr = 1'b0; // Unsupported, pc + 4 only
		endcase
		if (wr && ins[11:7] != 5'd0) begin
			ref_regs[ins[11:7]] = res;
		end
		return nxt;
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	task automatic emit(input logic [31:0] word);
		logic [31:0] addr;
		addr = `FWRISC_RESET_VECTOR + prog_len * 4;
		imem[addr[9:2]] = word;
		prog_len++;
	endtask

	task automatic store_reg(input logic [4:0] rs2); // SW rs2, slot(x0)
		emit({slot_addr[11:5], rs2, 5'd0, 3'b010, slot_addr[4:0], OPC_STORE});
		slot_addr = slot_addr + 32'd4;
	endtask

	// One taken and one fall-through branch, each skipping an increment of x9
	task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
			input logic [4:0] n1, input logic [4:0] n2);
		emit(b_type(13'd8, t2, t1, f3));
		emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, OPC_OP_IMM));
		emit(b_type(13'd8, n2, n1, f3));
		emit(i_type(12'd1, 5'd9, 3'b000, 5'd9, OPC_OP_IMM));
	endtask

	task automatic build_program();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [11:0] imm;
		emit(i_type(12'h040, 5'd0, 3'b010, 5'd5, OPC_LOAD)); // Preloaded words
		store_reg(5'd5);
		emit(i_type(12'h084, 5'd0, 3'b010, 5'd6, OPC_LOAD));
		store_reg(5'd6);
		emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, OPC_OP_IMM)); // Writes to x0
		emit(u_type(20'habcde, 5'd0, OPC_LUI));
		emit(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd0));
		store_reg(5'd0);
		emit(i_type(12'hffb, 5'd0, 3'b000, 5'd7, OPC_OP_IMM)); // x7 = -5
		emit(i_type(12'h003, 5'd0, 3'b000, 5'd8, OPC_OP_IMM)); // x8 = 3
		branch_pair(BR_BEQ, 5'd7, 5'd7, 5'd7, 5'd8);
		branch_pair(BR_BNE, 5'd7, 5'd8, 5'd7, 5'd7);
		branch_pair(BR_BLT, 5'd7, 5'd8, 5'd8, 5'd7);
		branch_pair(BR_BGE, 5'd8, 5'd7, 5'd7, 5'd8);
		branch_pair(BR_BLTU, 5'd8, 5'd7, 5'd7, 5'd8);
		branch_pair(BR_BGEU, 5'd7, 5'd8, 5'd8, 5'd7);
		store_reg(5'd9);
		emit(j_type(21'd8, 5'd10));
		emit(i_type(12'd1, 5'd0, 3'b000, 5'd11, OPC_OP_IMM)); // Skipped
		store_reg(5'd10);
		emit(u_type(20'h00000, 5'd12, OPC_AUIPC));
		emit(i_type(12'd13, 5'd12, 3'b000, 5'd13, OPC_JALR)); // Odd target, bit 0 dropped
		emit(i_type(12'd2, 5'd11, 3'b000, 5'd11, OPC_OP_IMM)); // Skipped
		store_reg(5'd13);
		store_reg(5'd11);
		for (int k = 0; k < 60; k++) begin
			r   = next_random();
			rd  = 5'd1 + r[3:0] % 15;
			f3  = r[15:13];
			imm = r[27:16];
			case (r[29:28])
				2'd0: emit(r_type(((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'h20 : 7'h00,
					{1'b0, r[12:9]}, {1'b0, r[8:5]}, f3, rd));
				2'd1: emit(u_type(r[31:12], rd, r[30] ? OPC_AUIPC : OPC_LUI));
				default: begin
					if (f3 == 3'b001) begin
						imm = {7'h00, imm[4:0]};
					end else if (f3 == 3'b101) begin
						imm = {r[30] ? 7'h20 : 7'h00, imm[4:0]};
					end
					emit(i_type(imm, {1'b0, r[8:5]}, f3, rd, OPC_OP_IMM));
				end
			endcase
			store_reg(rd);
		end
		halt_pc = `FWRISC_RESET_VECTOR + prog_len * 4;
		emit(j_type(21'd0, 5'd0));
	endtask

	// Memory models, about one stall in four on each port
	always @(negedge clock) begin
		iready     = (next_random() & 32'h3) != 0;
		idata      = imem[iaddr[9:2]];
		fetch_fire = (ivalid === 1'b1) && iready;
		fetch_addr = iaddr;
		dready     = (next_random() & 32'h3) != 0;
		drdata     = dmem[daddr[9:2]];
		store_fire = (dvalid === 1'b1) && (dwrite === 1'b1) && dready;
		if (store_fire) begin
			store_addr = daddr;
			store_data = dwdata;
			store_strb = dstrb;
			dmem[daddr[9:2]] = dwdata;
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			if (fetch_fire) begin
				check_value("iaddr", fetch_addr, exp_pc);
				if (exp_pc == halt_pc) begin
					halt_hits++;
				end
				exp_pc = ref_step(exp_pc, imem[exp_pc[9:2]]);
			end
			if (store_fire) begin
				if (exp_addr_q.size() == 0) begin
					report_failure("a store appeared on the data port when none was expected");
				end else begin
					check_value("daddr", store_addr, exp_addr_q.pop_front());
					check_value("dwdata", store_data, exp_data_q.pop_front());
					check_value("dstrb", {28'd0, store_strb}, 32'h0000_000f);
				end
			end
			if (dut_i.u_control.sva_i.assert_failed) begin
				report_failure("a port protocol assertion failed");
			end
		end
	end

	always @(posedge clock) begin
		if (!reset) begin
			cycles++;
			if (cycles > cycle_limit) begin
				report_failure($sformatf("timeout: halt loop not reached in %0d cycles", cycles));
			end
		end
	end

	initial begin
		reset     = 1'b1;
		iready    = 1'b0;
		dready    = 1'b0;
		idata     = '0;
		drdata    = '0;
		rng_state = 32'h7e6b;
		exp_pc    = `FWRISC_RESET_VECTOR;
		slot_addr = 32'h100;
		prog_len  = 0;
		halt_hits = 0;
		cycles    = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i]     = i_type(i[11:0], 5'd0, 3'b000, 5'd0, OPC_OP_IMM); // NOP tagged by index
			dmem[i]     = (i * 32'h9e37_79b1) ^ 32'hc0de_0000;
			ref_dmem[i] = dmem[i];
		end
		for (int i = 0; i < `FWRISC_NUM_REGS; i++) begin
			ref_regs[i] = '0;
		end
		build_program();
		cycle_limit = (prog_len + 3) * (4 + 8) * 2;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		wait (halt_hits >= 3);
		@(negedge clock);
		if (exp_addr_q.size() != 0) begin
			report_failure($sformatf("%0d expected stores never appeared", exp_addr_q.size()));
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

// ==== tests/fwrisc_tb_sva.sv ====
//==========================================================================
// Protocol checker for the instruction and data ports, bound into the
// control block so it sees the sequencing state as well.
//==========================================================================

`timescale 1ns/1ps

module fwrisc_tb_sva (
	input logic                     clock,
	input logic                     reset,
	input fwrisc_core_pkg::state_e  state,
	input logic                     ivalid,
	input logic                     iready,
	input logic [31:0]              iaddr,
	input logic                     dvalid,
	input logic                     dready,
	input logic [31:0]              daddr,
	input logic [31:0]              dwdata,
	input logic                     dwrite,
	output logic                    assert_failed
);
	import fwrisc_core_pkg::*;

	// One flag per assertion, each set only by its own action block
	logic bad_overlap = 1'b0;
	logic bad_ihold   = 1'b0;
	logic bad_dhold   = 1'b0;
	logic bad_align   = 1'b0;
	logic bad_decode  = 1'b0;

	assign assert_failed = bad_overlap | bad_ihold | bad_dhold | bad_align | bad_decode;

	a_no_overlap: assert property (@(posedge clock) disable iff (reset)
		!(ivalid && dvalid))
		else begin $error("ivalid and dvalid high together"); bad_overlap = 1'b1; end

	a_iaddr_hold: assert property (@(posedge clock) disable iff (reset)
		ivalid && !iready |=> ivalid && $stable(iaddr))
		else begin $error("fetch request dropped or changed while stalled"); bad_ihold = 1'b1; end

	a_dpayload_hold: assert property (@(posedge clock) disable iff (reset)
		dvalid && !dready |=> dvalid && $stable(daddr) && $stable(dwdata) && $stable(dwrite))
		else begin $error("data request dropped or changed while stalled"); bad_dhold = 1'b1; end

	a_daddr_aligned: assert property (@(posedge clock) disable iff (reset)
		dvalid |-> daddr[1:0] == 2'b00)
		else begin $error("daddr not word aligned"); bad_align = 1'b1; end

	// One DECODE cycle after each accepted fetch
	a_decode_one: assert property (@(posedge clock) disable iff (reset)
		ivalid && iready |=> state == ST_DECODE ##1 state == ST_EXECUTE)
		else begin $error("decode phase not exactly one cycle"); bad_decode = 1'b1; end

endmodule

bind fwrisc_control fwrisc_tb_sva sva_i (
	.clock         (clock),
	.reset         (reset),
	.state         (state),
	.ivalid        (ivalid),
	.iready        (iready),
	.iaddr         (iaddr),
	.dvalid        (dvalid),
	.dready        (dready),
	.daddr         (daddr),
	.dwdata        (dwdata),
	.dwrite        (dwrite),
	.assert_failed ()
);
